//--- logic/rv_core_config.svh
/* core-wide sizing macros: data width, register count, reset pc, phases per instruction */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// integer register count, x0 included
`define RV_NUM_REGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// cycles per instruction, fetch then execute
`define RV_NUM_PHASES 2

`endif

//--- logic/rv_core_pkg.sv
/* rv_core_pkg: word, register index, opcode, format, ALU op and select types */
`include "rv_core_config.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

    // major opcodes the core executes, everything else is a no-op
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_N   // no operands, unknown opcode
    } inst_fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {
        OPA_REG,
        OPA_PC,     // auipc
        OPA_ZERO    // lui
    } opa_sel_t;

    typedef enum logic {
        WB_ALU,
        WB_LINK     // jal / jalr return address
    } wb_sel_t;

endpackage

//--- logic/fetch_ctrl.sv
/* fetch_ctrl: fetch/execute phase counter, pc register and sequential pc */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module fetch_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  rv_core_pkg::word_t next_pc,
    output rv_core_pkg::word_t pc,
    output rv_core_pkg::word_t seq_pc,
    output logic               fetch_req,
    output logic               exec_phase
);
    import rv_core_pkg::*;

    localparam int unsigned PH_W = $clog2(`RV_NUM_PHASES);
    localparam int unsigned LAST_PH = `RV_NUM_PHASES - 1;

    logic [PH_W-1:0] phase;

    // phase 0 fetches, last phase executes
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
        end else if (exec_phase) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    assign fetch_req  = (phase == '0);
    assign exec_phase = (phase == PH_W'(LAST_PH));

    // pc only moves when an instruction completes
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (exec_phase) begin
            pc <= next_pc;
        end
    end

    assign seq_pc = pc + word_t'(4);

endmodule

//--- logic/inst_decoder.sv
/* inst_decoder: field split, format and immediate decode, ALU op and control decode */
`timescale 1ns/1ps

module inst_decoder (
    input  rv_core_pkg::word_t     instr,
    output rv_core_pkg::reg_idx_t  rd,
    output rv_core_pkg::reg_idx_t  rs1,
    output rv_core_pkg::reg_idx_t  rs2,
    output rv_core_pkg::word_t     imm,
    output rv_core_pkg::inst_fmt_t fmt,
    output rv_core_pkg::alu_op_t   alu_op,
    output rv_core_pkg::opa_sel_t  opa_sel,
    output logic                   use_imm,
    output logic                   is_branch,
    output logic                   is_jal,
    output logic                   is_jalr,
    output logic                   reg_write,
    output logic [2:0]             funct3,
    output rv_core_pkg::wb_sel_t   wb_sel
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic       writes_rd;  // opcode has a destination

    assign opcode = instr[6:0];
    assign funct7 = instr[31:25];
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        case (opcode)
            OPC_OP:                        fmt = FMT_R;
            OPC_OP_IMM, OPC_JALR:          fmt = FMT_I;
            OPC_BRANCH:                    fmt = FMT_B;
            OPC_LUI, OPC_AUIPC:            fmt = FMT_U;
            OPC_JAL:                       fmt = FMT_J;
            default:                       fmt = FMT_N;
        endcase
    end

    // sign-extended immediates per format
    always_comb begin
        case (fmt)
            FMT_I:   imm = {{20{instr[31]}}, instr[31:20]};
            FMT_B:   imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            FMT_U:   imm = {instr[31:12], 12'b0};
            FMT_J:   imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        opa_sel   = OPA_REG;
        use_imm   = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        writes_rd = 1'b0;
        wb_sel    = WB_ALU;
        case (opcode)
            OPC_OP:     writes_rd = 1'b1;
            OPC_OP_IMM: begin
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_LUI: begin
                opa_sel   = OPA_ZERO;   // 0 + imm
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_AUIPC: begin
                opa_sel   = OPA_PC;
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_JAL: begin
                is_jal    = 1'b1;
                writes_rd = 1'b1;
                wb_sel    = WB_LINK;
            end
            OPC_JALR: begin
                is_jalr   = 1'b1;
                use_imm   = 1'b1;
                writes_rd = 1'b1;
                wb_sel    = WB_LINK;
            end
            OPC_BRANCH: is_branch = 1'b1;
            default: ;  // unknown opcode runs as a no-op
        endcase
    end

    assign reg_write = writes_rd && (rd != '0);

    // funct3/funct7 only matter for the arithmetic opcodes
    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            case (funct3)
                3'b000:  alu_op = (fmt == FMT_R && funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

endmodule

//--- logic/reg_file.sv
/* reg_file: integer register file, two combinational reads, one write, x0 hardwired */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  rv_core_pkg::reg_idx_t waddr,
    input  rv_core_pkg::reg_idx_t raddr1,
    input  rv_core_pkg::reg_idx_t raddr2,
    input  rv_core_pkg::word_t    wdata,
    output rv_core_pkg::word_t    rdata1,
    output rv_core_pkg::word_t    rdata2
);
    import rv_core_pkg::*;

    word_t regs [`RV_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 always reads zero
    always_comb begin
        rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
        rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
    end

endmodule

//--- logic/alu_unit.sv
/* alu_unit: operand A/B selection and the ten RV32I integer operations */
`timescale 1ns/1ps

module alu_unit (
    input  rv_core_pkg::alu_op_t  alu_op,
    input  rv_core_pkg::opa_sel_t opa_sel,
    input  logic                  use_imm,
    input  rv_core_pkg::word_t    rs1_data,
    input  rv_core_pkg::word_t    rs2_data,
    input  rv_core_pkg::word_t    imm,
    input  rv_core_pkg::word_t    pc,
    output rv_core_pkg::word_t    alu_result
);
    import rv_core_pkg::*;

    word_t      opa;
    word_t      opb;
    logic [4:0] shamt;

    always_comb begin
        case (opa_sel)
            OPA_PC:   opa = pc;       // auipc
            OPA_ZERO: opa = '0;       // lui
            default:  opa = rs1_data;
        endcase
    end

    assign opb   = use_imm ? imm : rs2_data;
    assign shamt = opb[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = opa + opb;
            ALU_SUB:  alu_result = opa - opb;
            ALU_SLL:  alu_result = opa << shamt;
            ALU_SLT:  alu_result = word_t'($signed(opa) < $signed(opb));
            ALU_SLTU: alu_result = word_t'(opa < opb);
            ALU_XOR:  alu_result = opa ^ opb;
            ALU_SRL:  alu_result = opa >> shamt;
            ALU_SRA:  alu_result = word_t'($signed(opa) >>> shamt);
            ALU_OR:   alu_result = opa | opb;
            ALU_AND:  alu_result = opa & opb;
            default:  alu_result = opa + opb;
        endcase
    end

endmodule

//--- logic/branch_unit.sv
/* branch_unit: conditional branch compare and jump target for branches, jal and jalr */
`timescale 1ns/1ps

module branch_unit (
    input  logic               is_branch,
    input  logic               is_jal,
    input  logic               is_jalr,
    input  logic [2:0]         funct3,
    input  rv_core_pkg::word_t rs1_data,
    input  rv_core_pkg::word_t rs2_data,
    input  rv_core_pkg::word_t imm,
    input  rv_core_pkg::word_t pc,
    output logic               take_jump,
    output rv_core_pkg::word_t jump_target
);
    import rv_core_pkg::*;

    logic  cond;
    word_t base;
    word_t sum;

    always_comb begin
        case (funct3)
            3'b000:  cond = (rs1_data == rs2_data);                    // beq
            3'b001:  cond = (rs1_data != rs2_data);                    // bne
            3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));   // blt
            3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));  // bge
            3'b110:  cond = (rs1_data < rs2_data);                     // bltu
            3'b111:  cond = (rs1_data >= rs2_data);                    // bgeu
            default: cond = 1'b0;
        endcase
    end

    // jalr is register relative, the rest pc relative
    assign base = is_jalr ? rs1_data : pc;
    assign sum  = base + imm;

    assign jump_target = is_jalr ? {sum[$bits(word_t)-1:1], 1'b0} : sum;
    assign take_jump   = is_jal || is_jalr || (is_branch && cond);

endmodule

//--- logic/commit_unit.sv
/* commit_unit: write-back and next-pc selection, registered retire report */
`timescale 1ns/1ps

module commit_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  exec_phase,
    input  logic                  reg_write,
    input  logic                  take_jump,
    input  rv_core_pkg::wb_sel_t  wb_sel,
    input  rv_core_pkg::reg_idx_t rd,
    input  rv_core_pkg::word_t    alu_result,
    input  rv_core_pkg::word_t    jump_target,
    input  rv_core_pkg::word_t    seq_pc,
    output rv_core_pkg::word_t    next_pc,
    output rv_core_pkg::word_t    wdata,
    output logic                  we,
    output logic                  retire_valid,
    output rv_core_pkg::reg_idx_t retire_rd,
    output rv_core_pkg::word_t    retire_data
);
    import rv_core_pkg::*;

    assign wdata   = (wb_sel == WB_LINK) ? seq_pc : alu_result;  // link is pc + 4
    assign next_pc = take_jump ? jump_target : seq_pc;
    assign we      = reg_write && exec_phase;   // write lands at end of execute

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= we;
        end
    end

    // report mirrors the register write, one cycle late
    always_ff @(posedge clk) begin
        if (we) begin
            retire_rd   <= rd;
            retire_data <= wdata;
        end
    end

endmodule

//--- logic/rv_core_top.sv
/* rv_core_top: two-cycle RV32I integer core, fetch port in, retire report out */
`timescale 1ns/1ps

module rv_core_top (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::word_t    instr,
    output logic                  fetch_req,
    output rv_core_pkg::word_t    pc,
    output logic                  retire_valid,
    output rv_core_pkg::reg_idx_t retire_rd,
    output rv_core_pkg::word_t    retire_data
);
    import rv_core_pkg::*;

    word_t     seq_pc;
    word_t     next_pc;
    logic      exec_phase;

    reg_idx_t  rd;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    word_t     imm;
    alu_op_t   alu_op;
    opa_sel_t  opa_sel;
    logic      use_imm;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      reg_write;
    logic [2:0] funct3;
    wb_sel_t   wb_sel;

    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_result;
    logic      take_jump;
    word_t     jump_target;
    word_t     wdata;
    logic      we;

    fetch_ctrl u_fetch (
        .clk        (clk),
        .reset      (reset),
        .next_pc    (next_pc),
        .pc         (pc),
        .seq_pc     (seq_pc),
        .fetch_req  (fetch_req),
        .exec_phase (exec_phase)
    );

    inst_decoder u_dec (
        .instr     (instr),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm),
        .fmt       (),
        .alu_op    (alu_op),
        .opa_sel   (opa_sel),
        .use_imm   (use_imm),
        .is_branch (is_branch),
        .is_jal    (is_jal),
        .is_jalr   (is_jalr),
        .reg_write (reg_write),
        .funct3    (funct3),
        .wb_sel    (wb_sel)
    );

    reg_file u_rf (
        .clk    (clk),
        .reset  (reset),
        .we     (we),
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (wdata),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    alu_unit u_alu (
        .alu_op     (alu_op),
        .opa_sel    (opa_sel),
        .use_imm    (use_imm),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .pc         (pc),
        .alu_result (alu_result)
    );

    branch_unit u_br (
        .is_branch   (is_branch),
        .is_jal      (is_jal),
        .is_jalr     (is_jalr),
        .funct3      (funct3),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .pc          (pc),
        .take_jump   (take_jump),
        .jump_target (jump_target)
    );

    commit_unit u_commit (
        .clk          (clk),
        .reset        (reset),
        .exec_phase   (exec_phase),
        .reg_write    (reg_write),
        .take_jump    (take_jump),
        .wb_sel       (wb_sel),
        .rd           (rd),
        .alu_result   (alu_result),
        .jump_target  (jump_target),
        .seq_pc       (seq_pc),
        .next_pc      (next_pc),
        .wdata        (wdata),
        .we           (we),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

//--- verif/rv_core_properties.sv
/* rv_core_properties: fetch spacing, retire timing and pc alignment checks on rv_core_top */
`timescale 1ns/1ps

module rv_core_properties (
    input logic                  clk,
    input logic                  reset,
    input logic                  fetch_req,
    input rv_core_pkg::word_t    pc,
    input logic                  retire_valid,
    input rv_core_pkg::reg_idx_t retire_rd
);

    // one fetch per two-cycle instruction
    fetch_spaced: assert property (@(posedge clk) disable iff (reset)
        fetch_req |=> !fetch_req)
        else $error("fetch_req high in two consecutive cycles");

    // retire lands right after an execute cycle
    retire_after_exec: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> $past(!fetch_req))
        else $error("retire_valid not preceded by an execute cycle");

    retire_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> retire_rd != '0)
        else $error("retire reported for x0");

    pc_even: assert property (@(posedge clk) disable iff (reset)
        pc[0] == 1'b0)
        else $error("pc bit 0 set");

endmodule

bind rv_core_top rv_core_properties u_props (
    .clk          (clk),
    .reset        (reset),
    .fetch_req    (fetch_req),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd)
);

//--- verif/rv_core_tb.sv
/* rv_core_tb: clock, reset, instruction memory, ISA reference model, directed tests,
   watchdog and verdict for the two-cycle RV32I core */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int unsigned INSTR_COUNT  = 61;   // instructions issued by all tests
    localparam int unsigned CLK_NS       = 40;
    localparam int unsigned RESET_CYCLES = 8;
    localparam int unsigned WATCHDOG_NS  =
        INSTR_COUNT * `RV_NUM_PHASES * CLK_NS * 2 + RESET_CYCLES * CLK_NS;

    // major opcodes used to assemble test programs
    localparam logic [6:0] OP_R     = 7'b0110011;
    localparam logic [6:0] OP_I     = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;
    localparam logic [6:0] OP_BR    = 7'b1100011;

    logic     clk = 1'b0;
    logic     reset;
    word_t    instr;
    logic     fetch_req;
    word_t    pc;
    logic     retire_valid;
    reg_idx_t retire_rd;
    word_t    retire_data;

    word_t imem [4096];             // word index counted from the reset pc
    word_t mregs [`RV_NUM_REGS];    // reference register file
    word_t mpc;                     // reference pc
    int    num_checks = 0;
    int    num_errors = 0;

    rv_core_top uut (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .fetch_req    (fetch_req),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // instruction answers in the cycle after the fetch strobe
    always @(posedge clk) begin
        if (fetch_req && !reset) begin
            instr <= imem[12'((pc - `RV_RESET_PC) >> 2)];
        end
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        num_checks++;
        if (act !== exp) begin
            num_errors++;
            $display("** Error [%s] retire_data: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        num_checks++;
        if (act !== exp) begin
            num_errors++;
            $display("** Error [%s] retire_rd: expected x%0d, got x%0d", name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input word_t exp, input word_t act);
        num_checks++;
        if (act !== exp) begin
            num_errors++;
            $display("** Error [%s] fetch pc: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        num_checks++;
        if (act !== exp) begin
            num_errors++;
            $display("** Error [%s] retire_valid: expected %b, got %b", name, exp, act);
        end
    endtask

    function automatic word_t r_type(input logic [6:0] f7, input int rs2, rs1, f3, rd);
        return {f7, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OP_R};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input int rs1, f3, rd,
                                     input logic [6:0] opc);
        return {imm, 5'(rs1), 3'(f3), 5'(rd), opc};
    endfunction

    function automatic word_t b_type(input int off, input int rs1, rs2, f3);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], OP_BR};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input int rd,
                                     input logic [6:0] opc);
        return {imm, 5'(rd), opc};
    endfunction

    function automatic word_t j_type(input int off, input int rd);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), OP_JAL};
    endfunction

    // RV32I integer op by funct3, alt selects sub / arithmetic shift
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // issue one instruction at the model pc, then check fetch pc and retire report
    task automatic run_instr(input string name, input word_t inst);
        word_t      a;
        word_t      b;
        word_t      i_imm;
        word_t      b_imm;
        word_t      j_imm;
        word_t      data;
        word_t      npc;
        logic       wen;
        logic [2:0] f3;
        reg_idx_t   rd;

        while (!fetch_req) begin
            @(negedge clk);
        end
        check_pc(name, mpc, pc);
        imem[12'((mpc - `RV_RESET_PC) >> 2)] = inst;

        a     = mregs[inst[19:15]];
        b     = mregs[inst[24:20]];
        f3    = inst[14:12];
        rd    = inst[11:7];
        i_imm = {{20{inst[31]}}, inst[31:20]};
        b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        npc   = mpc + 4;
        wen   = 1'b1;
        data  = '0;
        case (inst[6:0])
            OP_R:     data = alu_ref(f3, inst[30], a, b);
            OP_I:     data = alu_ref(f3, inst[30] && f3 == 3'd5, a, i_imm);
            OP_LUI:   data = {inst[31:12], 12'h000};
            OP_AUIPC: data = mpc + {inst[31:12], 12'h000};
            OP_JAL: begin
                data = mpc + 4;
                npc  = mpc + j_imm;
            end
            OP_JALR: begin
                data = mpc + 4;
                npc  = (a + i_imm) & ~word_t'(1);
            end
            OP_BR: begin
                wen = 1'b0;
                if (branch_taken(f3, a, b)) begin
                    npc = mpc + b_imm;
                end
            end
            default: wen = 1'b0;    // dropped opcodes act as no-ops
        endcase
        if (rd == '0) begin
            wen = 1'b0;
        end

        @(negedge clk);     // execute
        @(negedge clk);     // next fetch, retire visible
        check_flag(name, wen, retire_valid);
        if (wen) begin
            check_reg(name, rd, retire_rd);
            check_word(name, data, retire_data);
            mregs[rd] = data;
        end
        mpc = npc;
    endtask

    task automatic test_reset();
        run_instr("reset", 32'h0000_0073);  // ecall
        run_instr("reset", 32'h0000_000f);  // fence
        run_instr("reset", 32'h0080_2083);  // lw x1, 8(x0)
    endtask

    task automatic test_arith();
        logic [11:0] imm;

        // x1 negative, x2 random with a nonzero shift amount
        run_instr("arith", u_type(20'($urandom) | 20'h80000, 1, OP_LUI));
        run_instr("arith", i_type(12'($urandom), 1, 0, 1, OP_I));
        run_instr("arith", u_type(20'($urandom), 2, OP_LUI));
        run_instr("arith", i_type(12'($urandom) | 12'h001, 2, 0, 2, OP_I));
        for (int f = 0; f < 8; f++) begin
            run_instr("arith", r_type(7'h00, 2, 1, f, 5));
            imm = (f == 1 || f == 5) ? 12'($urandom_range(31)) : 12'($urandom);
            run_instr("arith", i_type(imm, 1, f, 6, OP_I));
        end
        run_instr("arith", r_type(7'h20, 2, 1, 0, 7));     // sub
        run_instr("arith", r_type(7'h20, 2, 1, 5, 8));     // sra
        run_instr("arith", i_type(12'h400 | 12'($urandom_range(1, 31)), 1, 5, 9, OP_I));
        run_instr("arith", i_type(12'hffb, 0, 0, 3, OP_I));
        run_instr("arith", i_type(12'd3, 0, 0, 4, OP_I));
        run_instr("arith", r_type(7'h00, 4, 3, 2, 10));    // slt gives 1
        run_instr("arith", r_type(7'h00, 4, 3, 3, 11));    // sltu gives 0
    endtask

    task automatic test_upper();
        run_instr("upper", u_type(20'($urandom), 12, OP_LUI));
        run_instr("upper", u_type(20'($urandom), 16, OP_LUI));
        run_instr("upper", u_type(20'($urandom), 13, OP_AUIPC));
        run_instr("upper", u_type(20'($urandom), 17, OP_AUIPC));
    endtask

    task automatic test_branch();
        int conds [6] = '{0, 1, 4, 5, 6, 7};
        int lhs [3]   = '{10, 11, 11};
        int rhs [3]   = '{11, 10, 12};
        int off;

        // x10 = -2, x11 = x12 = 3: every condition is true and false at least once
        run_instr("branch", i_type(12'hffe, 0, 0, 10, OP_I));
        run_instr("branch", i_type(12'd3, 0, 0, 11, OP_I));
        run_instr("branch", i_type(12'd3, 0, 0, 12, OP_I));
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                off = 8 * (int'($urandom_range(10)) - 1);  // never pc + 4
                run_instr("branch", b_type(off, lhs[p], rhs[p], conds[c]));
            end
        end
    endtask

    task automatic test_jump();
        run_instr("jump", j_type(4 * int'($urandom_range(2, 32)), 1));
        run_instr("jump", j_type(-8, 0));                   // no link, no retire
        run_instr("jump", u_type(20'h0, 13, OP_AUIPC));
        run_instr("jump", i_type(12'd41, 13, 0, 14, OP_JALR)); // odd target, bit 0 dropped
        run_instr("jump", i_type(12'd77, 0, 0, 0, OP_I));   // write to x0
        run_instr("jump", r_type(7'h00, 5, 0, 0, 15));      // x0 must still read 0
    endtask

    initial begin
        void'($urandom(32'h664c));
        reset = 1'b1;
        instr = '0;
        mpc   = `RV_RESET_PC;
        foreach (mregs[i]) begin
            mregs[i] = '0;
        end

        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            check_flag("reset", 1'b0, retire_valid);
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        test_reset();
        test_arith();
        test_upper();
        test_branch();
        test_jump();

        $display("checks run: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns: the core stopped fetching", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- rv_core.f
+incdir+logic
logic/rv_core_pkg.sv
logic/fetch_ctrl.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/commit_unit.sv
logic/rv_core_top.sv
verif/rv_core_properties.sv
verif/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator, verdict taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module rv_core_tb \
    -f rv_core.f --Mdir "$OBJ" -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/rv_core_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
